//--- rtl/mul_macros.svh
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// operand and result width
`define MUL_XLEN 64

// multiplicand and accumulator, wide enough for any signed or unsigned product
`define MUL_EXT_WIDTH (2 * `MUL_XLEN + 2)

// one booth digit per two multiplier bits, 66 bit multiplier
`define MUL_MAX_ITER 33

`endif

//--- rtl/mul_pkg.sv
`include "mul_macros.svh"

package mul_pkg;

	// architectural operand or result
	typedef logic [`MUL_XLEN-1:0] xlen_t;

	// extended multiplicand, partial product and accumulator
	typedef logic [`MUL_EXT_WIDTH-1:0] ext_t;

	// multiplier with two extension bits
	typedef logic [`MUL_XLEN+1:0] mcand_y_t;

	typedef enum logic [2:0] {
		OP_MUL,
		OP_MULH,
		OP_MULHSU,
		OP_MULHU,
		OP_MULW
	} mul_op_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_FIRST, // first digit straight from the prep registers
		S_STEP,
		S_LAST
	} booth_state_t;

endpackage

//--- rtl/mul_operand_prep.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

module mul_operand_prep import mul_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     start,
	input  logic     busy,
	input  mul_op_t  op,
	input  xlen_t    src1,
	input  xlen_t    src2,
	output ext_t     alu_x,
	output mcand_y_t alu_y,
	output mul_op_t  op_q
);

	localparam int X_PAD = `MUL_EXT_WIDTH - `MUL_XLEN;
	localparam int Y_PAD = 2;

	logic accept;
	logic x_signed;
	logic y_signed;
	logic x_fill;
	logic y_fill;

	assign accept = start & ~busy;

	// signedness of each source by operation
	always_comb begin
		case (op)
			OP_MULHU: begin
				x_signed = 1'b0;
				y_signed = 1'b0;
			end
			OP_MULHSU: begin
				x_signed = 1'b1;
				y_signed = 1'b0;
			end
			default: begin // MUL, MULH, MULW
				x_signed = 1'b1;
				y_signed = 1'b1;
			end
		endcase
		x_fill = x_signed & src1[`MUL_XLEN-1];
		y_fill = y_signed & src2[`MUL_XLEN-1];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q <= OP_MUL;
		end else if (accept) begin
			op_q <= op;
		end
	end

	// operands stay put for the whole run
	always_ff @(posedge clk) begin
		if (accept) begin
			alu_x <= {{X_PAD{x_fill}}, src1};
			alu_y <= {{Y_PAD{y_fill}}, src2};
		end
	end

endmodule

//--- rtl/booth_radix4_core.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

module booth_radix4_core import mul_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     start,
	input  ext_t     alu_x,
	input  mcand_y_t alu_y,
	output logic     busy,
	output logic     done,
	output ext_t     product
);

	localparam int Y_W = `MUL_XLEN + 2;

	booth_state_t state;
	booth_state_t state_nxt;

	ext_t              mcand_q;  // multiplicand aligned to the current digit
	mcand_y_t          mplier_q; // bits not yet recoded with the window at [1:0]
	logic              prev_q;   // low bit of the recoding window
	ext_t              acc_q;
	logic              done_q;

	ext_t     cur_x;
	mcand_y_t cur_y;
	logic     cur_prev;
	ext_t     acc_base;
	logic [2:0] win;
	ext_t     pp;
	ext_t     mcand_nxt;
	mcand_y_t mplier_nxt;
	logic     rest_zero;

	// radix-4 digit of 0, +-x or +-2x
	function automatic ext_t booth_pp(input logic [2:0] w, input ext_t x);
		ext_t x2;
		x2 = x << 1;
		case (w)
			3'b001, 3'b010: return x;
			3'b011:         return x2;
			3'b100:         return ~x2 + 1'b1;
			3'b101, 3'b110: return ~x + 1'b1;
			default:        return '0;
		endcase
	endfunction

	// first digit comes straight off the prep registers
	always_comb begin
		if (state == S_FIRST) begin
			cur_x    = alu_x;
			cur_y    = alu_y;
			cur_prev = 1'b0;
			acc_base = '0;
		end else begin
			cur_x    = mcand_q;
			cur_y    = mplier_q;
			cur_prev = prev_q;
			acc_base = acc_q;
		end
	end

	always_comb begin
		win        = {cur_y[1:0], cur_prev};
		pp         = booth_pp(win, cur_x);
		mcand_nxt  = cur_x << 2;
		mplier_nxt = mcand_y_t'($signed(cur_y) >>> 2);
		// next digit is the last nonzero one when everything above it is sign fill
		rest_zero  = (&mplier_nxt[Y_W-1:1]) | ~(|mplier_nxt[Y_W-1:1]);
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (start)
					state_nxt = S_FIRST;
			end
			S_FIRST, S_STEP: begin
				if (rest_zero)
					state_nxt = S_LAST;
				else
					state_nxt = S_STEP;
			end
			S_LAST:  state_nxt = S_IDLE;
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= S_IDLE;
			done_q <= 1'b0;
		end else begin
			state  <= state_nxt;
			done_q <= (state == S_LAST);
		end
	end

	// accumulator keeps the product after the run
	always_ff @(posedge clk) begin
		if (state != S_IDLE) begin
			acc_q    <= acc_base + pp;
			mcand_q  <= mcand_nxt;
			mplier_q <= mplier_nxt;
			prev_q   <= cur_y[1];
		end
	end

	assign busy    = (state != S_IDLE);
	assign done    = done_q;
	assign product = acc_q;

endmodule

//--- rtl/mul_result_sel.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

module mul_result_sel import mul_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    done,
	input  mul_op_t op_q,
	input  ext_t    product,
	output xlen_t   result
);

	localparam int XLEN = `MUL_XLEN;
	localparam int HALF = `MUL_XLEN / 2;

	xlen_t lo_word;
	xlen_t hi_word;
	xlen_t w_word;
	xlen_t sel;

	always_comb begin
		lo_word = product[XLEN-1:0];
		hi_word = product[2*XLEN-1:XLEN];
		w_word  = {{HALF{product[HALF-1]}}, product[HALF-1:0]}; // low word, sign extended
	end

	always_comb begin
		case (op_q)
			OP_MUL:    sel = lo_word;
			OP_MULW:   sel = w_word;
			OP_MULH,
			OP_MULHSU,
			OP_MULHU:  sel = hi_word;
			default:   sel = lo_word;
		endcase
	end

	// held until the next done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
		end else if (done) begin
			result <= sel;
		end
	end

endmodule

//--- rtl/mul_unit.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

module mul_unit import mul_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start,
	input  mul_op_t op,
	input  xlen_t   src1,
	input  xlen_t   src2,
	output logic    busy,
	output logic    done,
	output xlen_t   result
);

	logic     start_ok; // starts while busy are dropped
	ext_t     alu_x;
	mcand_y_t alu_y;
	mul_op_t  op_q;
	ext_t     product;

	assign start_ok = start & ~busy;

	mul_operand_prep u_prep (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.busy  (busy),
		.op    (op),
		.src1  (src1),
		.src2  (src2),
		.alu_x (alu_x),
		.alu_y (alu_y),
		.op_q  (op_q)
	);

	booth_radix4_core u_core (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start_ok),
		.alu_x   (alu_x),
		.alu_y   (alu_y),
		.busy    (busy),
		.done    (done),
		.product (product)
	);

	mul_result_sel u_sel (
		.clk     (clk),
		.rst_n   (rst_n),
		.done    (done),
		.op_q    (op_q),
		.product (product),
		.result  (result)
	);

endmodule

//--- tests/mul_unit_sva.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

module mul_unit_sva (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic done
);

	logic [5:0] busy_run; // busy cycles so far in this run
	logic       seen_start;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_run   <= '0;
			seen_start <= 1'b0;
		end else begin
			if (busy)
				busy_run <= busy_run + 1'b1;
			else
				busy_run <= '0;
			if (start)
				seen_start <= 1'b1;
		end
	end

	a_done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(busy))
		else $error("done rose without busy in the previous cycle");

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done held for more than one cycle");

	// at most MUL_MAX_ITER + 1 busy cycles
	a_busy_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		busy_run <= 6'(`MUL_MAX_ITER + 1))
		else $error("busy stayed high too long");

	a_quiet_until_start: assert property (@(posedge clk) disable iff (!rst_n)
		!seen_start |-> (!busy && !done))
		else $error("busy or done active before the first start");

endmodule

bind mul_unit mul_unit_sva u_sva (
	.clk   (clk),
	.rst_n (rst_n),
	.start (start),
	.busy  (busy),
	.done  (done)
);

//--- tests/tb_mul_unit.sv
`timescale 1ns/1ps
`include "mul_macros.svh"

module tb_mul_unit import mul_pkg::*; ();

	localparam int    NUM_VEC        = 26;
	localparam int    NUM_RAND       = 200;
	localparam int    MAX_LAT        = `MUL_MAX_ITER + 1;
	localparam int    TIMEOUT_CYCLES = (NUM_VEC + NUM_RAND) * 40 + 100;
	localparam xlen_t ONES           = {64{1'b1}};
	localparam xlen_t MIN_NEG        = 64'h8000_0000_0000_0000;

	typedef struct packed {
		mul_op_t op;
		xlen_t   a;
		xlen_t   b;
		xlen_t   exp;
		logic    poke; // second start while busy
	} vec_t;

	logic    clk;
	logic    rst_n;
	logic    start;
	mul_op_t op;
	xlen_t   src1;
	xlen_t   src2;
	logic    busy;
	logic    done;
	xlen_t   result;

	vec_t  vecs [NUM_VEC];
	int    nvec;
	xlen_t last_result; // result holds this until the next done
	int    cycles = 0;
	int    seed;

	mul_unit DUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.op     (op),
		.src1   (src1),
		.src2   (src2),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the run did not finish", cycles);
			stop_fail();
		end
	end

	task automatic stop_fail();
		$display(">>> FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic fail_msg(input string what);
		$display("error at %0t ns: %s", $time, what);
		stop_fail();
	endtask

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_fail();
		end
	endtask

	// architectural result from a 128-bit product of the extended sources
	function automatic xlen_t ref_result(input mul_op_t o, input xlen_t a, input xlen_t b);
		logic [127:0] xa;
		logic [127:0] xb;
		logic [127:0] p;
		xa = {{64{a[63]}}, a};
		xb = {{64{b[63]}}, b};
		if (o == OP_MULHU)
			xa = {64'd0, a};
		if (o == OP_MULHU || o == OP_MULHSU)
			xb = {64'd0, b};
		p = xa * xb; // modulo 2^128 which is exact for either signedness
		case (o)
			OP_MUL:  return p[63:0];
			OP_MULW: return {{32{p[31]}}, p[31:0]};
			default: return p[127:64];
		endcase
	endfunction

	task automatic add_vec(input mul_op_t o, input xlen_t a, input xlen_t b, input xlen_t e,
		input logic pk);
		vecs[nvec] = '{op: o, a: a, b: b, exp: e, poke: pk};
		nvec++;
	endtask

	task automatic build_table();
		add_vec(OP_MUL, 64'd0, 64'h3039, 64'd0, 1'b0);
		add_vec(OP_MUL, 64'd1, 64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef, 1'b0);
		add_vec(OP_MUL, ONES, 64'd5, 64'hffff_ffff_ffff_fffb, 1'b0);
		add_vec(OP_MUL, MIN_NEG, ONES, MIN_NEG, 1'b0);
		add_vec(OP_MUL, 64'd3, 64'hffff_ffff_ffff_fff9, 64'hffff_ffff_ffff_ffeb, 1'b0);
		add_vec(OP_MUL, MIN_NEG, MIN_NEG, 64'd0, 1'b0);
		add_vec(OP_MULW, 64'h7fff_ffff, 64'd2, 64'hffff_ffff_ffff_fffe, 1'b0);
		add_vec(OP_MULW, 64'h1_0000, 64'h1_0000, 64'd0, 1'b0);
		add_vec(OP_MULW, 64'hffff_ffff_ffff_fffd, 64'd4, 64'hffff_ffff_ffff_fff4, 1'b0);
		add_vec(OP_MULW, 64'h1234_5678_0000_0005, 64'd3, 64'hf, 1'b0);
		// same operands through the three high-half ops
		add_vec(OP_MULH, ONES, ONES, 64'd0, 1'b0);
		add_vec(OP_MULHSU, ONES, ONES, ONES, 1'b0);
		add_vec(OP_MULHU, ONES, ONES, 64'hffff_ffff_ffff_fffe, 1'b0);
		add_vec(OP_MULH, MIN_NEG, MIN_NEG, 64'h4000_0000_0000_0000, 1'b1);
		add_vec(OP_MULHSU, MIN_NEG, MIN_NEG, 64'hc000_0000_0000_0000, 1'b0);
		add_vec(OP_MULHU, MIN_NEG, MIN_NEG, 64'h4000_0000_0000_0000, 1'b0);
		add_vec(OP_MULH, 64'd2, ONES, ONES, 1'b0);
		add_vec(OP_MULHSU, 64'd2, ONES, 64'd1, 1'b0);
		add_vec(OP_MULHU, 64'd2, ONES, 64'd1, 1'b0);
		add_vec(OP_MULH, 64'hffff_ffff_ffff_fffe, 64'd3, ONES, 1'b0);
		add_vec(OP_MULHSU, 64'hffff_ffff_ffff_fffe, 64'd3, ONES, 1'b0);
		add_vec(OP_MULHU, 64'hffff_ffff_ffff_fffe, 64'd3, 64'd2, 1'b0);
		add_vec(OP_MULH, 64'h1_0000_0000, 64'h1_0000_0000, 64'd1, 1'b0);
		add_vec(OP_MUL, 64'd7, 64'h5555_5555_5555_5555, 64'h5555_5555_5555_5553, 1'b1);
		add_vec(OP_MULHU, 64'd0, 64'd0, 64'd0, 1'b0);
		add_vec(OP_MUL, 64'hffff_ffff_ffff_fffe, 64'hffff_ffff_ffff_fffd, 64'd6, 1'b0);
	endtask

	// runs one operation to its checked result and returns the edges up to done
	task automatic run_op(input mul_op_t o, input xlen_t a, input xlen_t b, input xlen_t exp,
		input logic poke, output int lat);
		int n;
		start = 1'b1;
		op    = o;
		src1  = a;
		src2  = b;
		@(posedge clk);
		#1;
		start = 1'b0;
		check_eq("busy", busy, 1);
		if (poke) begin
			start = 1'b1; // dropped while the unit is busy
			op    = (o == OP_MULW) ? OP_MUL : OP_MULW;
			src1  = ~a;
			src2  = 64'h5a5a_5a5a_5a5a_5a5a;
		end
		n = 1;
		while (!done && n <= MAX_LAT) begin
			check_eq("result", result, last_result);
			@(posedge clk);
			#1;
			start = 1'b0;
			n++;
		end
		assert (done) else fail_msg($sformatf("no done within %0d cycles of start", MAX_LAT));
		assert (n <= MAX_LAT) else fail_msg($sformatf("operation took %0d cycles", n));
		check_eq("busy", busy, 0);
		check_eq("result", result, last_result);
		@(posedge clk);
		#1;
		check_eq("done", done, 0);
		check_eq("result", result, exp);
		last_result = exp;
		lat = n;
	endtask

	initial begin
		int          lat;
		int          lat_one;
		int          lat_neg;
		int          lat_full;
		int unsigned r;
		mul_op_t     rop;
		xlen_t       ra;
		xlen_t       rb;
		rst_n       = 1'b0;
		start       = 1'b0;
		op          = OP_MUL;
		src1        = '0;
		src2        = '0;
		seed        = 32'h62fb_2610;
		last_result = '0;
		nvec        = 0;
		build_table();
		assert (nvec == NUM_VEC) else fail_msg("stimulus table length does not match NUM_VEC");

		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_eq("busy", busy, 0);
		check_eq("done", done, 0);
		check_eq("result", result, 0);

		for (int i = 0; i < NUM_VEC; i++) begin
			assert (ref_result(vecs[i].op, vecs[i].a, vecs[i].b) == vecs[i].exp)
				else fail_msg($sformatf("reference model disagrees with table row %0d", i));
			run_op(vecs[i].op, vecs[i].a, vecs[i].b, vecs[i].exp, vecs[i].poke, lat);
		end

		// early termination on short multipliers
		run_op(OP_MUL, 64'd7, 64'd1, ref_result(OP_MUL, 64'd7, 64'd1), 1'b0, lat_one);
		run_op(OP_MUL, 64'd7, ONES, ref_result(OP_MUL, 64'd7, ONES), 1'b0, lat_neg);
		run_op(OP_MUL, 64'd7, 64'h5555_5555_5555_5555,
			ref_result(OP_MUL, 64'd7, 64'h5555_5555_5555_5555), 1'b0, lat_full);
		assert (lat_one < lat_full)
			else fail_msg("multiplier of one did not finish sooner than a full-width one");
		assert (lat_neg < lat_full)
			else fail_msg("multiplier of minus one did not finish sooner than a full-width one");

		for (int i = 0; i < NUM_RAND; i++) begin
			r   = $random(seed);
			rop = mul_op_t'(3'(r % 5));
			ra  = {$random(seed), $random(seed)};
			rb  = {$random(seed), $random(seed)};
			if (r[10:8] == 3'd0)
				rb = {{56{rb[7]}}, rb[7:0]}; // short multiplier
			run_op(rop, ra, rb, ref_result(rop, ra, rb), r[11], lat);
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

//--- sim.f
+incdir+rtl
rtl/mul_pkg.sv
rtl/mul_operand_prep.sv
rtl/booth_radix4_core.sv
rtl/mul_result_sel.sv
rtl/mul_unit.sv
tests/mul_unit_sva.sv
tests/tb_mul_unit.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mul_unit
FILELIST   := sim.f
FLAGS      := --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(FLAGS) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --binary --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q -- "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
